//--- all.f
verilog/cpu_isa_pkg.sv
verilog/cpu_bus_pkg.sv
verilog/instr_fetch.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/exec_unit.sv
verilog/mem_port.sv
verilog/cpu_top.sv
sim/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module cpu_tb -o cpu_tb_sim &&
./obj_dir/cpu_tb_sim | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation did not pass" >&2; exit 1; }

//--- sim/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  localparam int          CLK_PERIOD  = 40;
  localparam int          TOTAL_INSTR = 140;  // 14 + 20 + 17 + 35 + 30 + 24
  localparam logic [15:0] PROG_BASE   = 16'h0100;
  localparam logic [15:0] DATA_BASE   = 16'hC000;
  localparam logic [2:0]  R_B = 3'd0;
  localparam logic [2:0]  R_C = 3'd1;
  localparam logic [2:0]  R_D = 3'd2;
  localparam logic [2:0]  R_E = 3'd3;
  localparam logic [2:0]  R_H = 3'd4;
  localparam logic [2:0]  R_L = 3'd5;
  localparam logic [2:0]  R_A = 3'd7;

  logic        clk;
  logic        rst;
  logic [7:0]  mem_rd_data;
  logic [15:0] mem_rd_addr;
  logic        mem_wr_en;
  logic [15:0] mem_wr_addr;
  logic [7:0]  mem_wr_data;

  logic [7:0]  mem [65536];
  logic [7:0]  prog [$];
  logic [15:0] exp_addr [$];
  logic [7:0]  exp_data [$];
  logic [15:0] log_addr [$];
  logic [7:0]  log_data [$];
  logic [7:0]  model_regs [8];
  logic        model_carry;
  logic [31:0] rng_state;
  int          test_errs;
  int          bus_errs;
  int          bus_base;
  int          pass_cnt;
  int          fail_cnt;

  cpu_top cpu_top_i (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_mem_rd_data(mem_rd_data),
    .o_mem_rd_addr(mem_rd_addr),
    .o_mem_wr_en  (mem_wr_en),
    .o_mem_wr_addr(mem_wr_addr),
    .o_mem_wr_data(mem_wr_data)
  );

  assign mem_rd_data = mem[mem_rd_addr];  // always-ready memory

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic void bus_fault(string msg);
    $display("ERROR at %0t: %s", $time, msg);
    bus_errs++;
  endfunction

  ap_strobe_one_clock: assert property (@(posedge clk) disable iff (rst)
    mem_wr_en |=> !mem_wr_en)
    else bus_fault("write strobe stayed high for more than one clock");

  ap_quiet_after_reset: assert property (@(posedge clk) $past(rst) |-> !mem_wr_en)
    else bus_fault("write strobe was high right after reset");

  ap_write_in_data_area: assert property (@(posedge clk) disable iff (rst)
    mem_wr_en |-> mem_wr_addr >= DATA_BASE)
    else bus_fault("a write landed outside the data area");

  ap_fetch_start: assert property (@(posedge clk) disable iff (rst)
    ($past(mem_rd_addr) == 16'h0000 && mem_rd_addr != 16'h0000) |-> mem_rd_addr == PROG_BASE)
    else bus_fault("first fetch did not start at the reset program counter");

  // fetch addresses step by one except next to data reads
  ap_fetch_order: assert property (@(posedge clk) disable iff (rst)
    (mem_rd_addr != $past(mem_rd_addr) && $past(mem_rd_addr) != 16'h0000 &&
     mem_rd_addr != 16'h0000 && $past(mem_rd_addr) < DATA_BASE && mem_rd_addr < DATA_BASE)
    |-> mem_rd_addr == 16'($past(mem_rd_addr) + 16'd1))
    else bus_fault("fetch address did not move to the next byte");

  initial begin
    #(TOTAL_INSTR * 3 * 4 * CLK_PERIOD * 2);
    $display("simulation timed out, the program end was never fetched");
    $display("TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [7:0] next_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
  endfunction

  function automatic logic [2:0] work_reg(int i);
    return (i == 4) ? R_A : 3'(i);  // B C D E A
  endfunction

  function automatic logic [2:0] pick_reg();
    logic [7:0] b;
    logic [2:0] r;
    b = next_byte();
    r = b[2:0];
    if (r >= R_H && r <= 3'd6)
      r = b[7] ? R_A : {1'b0, b[4:3]};  // keep H and L out so HL stays put
    return r;
  endfunction

  task automatic load_immediate(input logic [2:0] r, input logic [7:0] n);
    prog.push_back({2'b00, r, 3'b110});
    prog.push_back(n);
    model_regs[r] = n;
  endtask

  task automatic copy_register(input logic [2:0] d, input logic [2:0] s);
    prog.push_back({2'b01, d, s});
    model_regs[d] = model_regs[s];
  endtask

  task automatic step_register(input logic [2:0] r, input logic dec);
    prog.push_back({2'b00, r, 2'b10, dec});
    model_regs[r] = dec ? model_regs[r] - 8'd1 : model_regs[r] + 8'd1;
  endtask

  task automatic add_to_a(input logic [2:0] s, input logic with_carry);
    logic [8:0] sum;
    sum = {1'b0, model_regs[R_A]} + {1'b0, model_regs[s]} + {8'd0, with_carry & model_carry};
    prog.push_back({4'b1000, with_carry, s});
    model_regs[R_A] = sum[7:0];
    model_carry     = sum[8];
  endtask

  task automatic read_hl_byte(input logic [2:0] r, input logic [7:0] v);
    mem[{model_regs[R_H], model_regs[R_L]}] = v;  // byte waiting at HL
    prog.push_back({2'b01, r, 3'b110});
    model_regs[r] = v;
  endtask

  task automatic store_to_hl(input logic [2:0] r);
    prog.push_back({2'b01, 3'b110, r});
    exp_addr.push_back({model_regs[R_H], model_regs[R_L]});
    exp_data.push_back(model_regs[r]);
  endtask

  task automatic set_hl(input logic [7:0] h);
    load_immediate(R_H, h);
    load_immediate(R_L, next_byte());
  endtask

  task automatic begin_test();
    @(posedge clk);
    rst <= 1'b1;
    for (int a = 0; a < 65536; a++)
      mem[16'(a)] = 8'(a ^ (a >> 8));
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    log_addr.delete();
    log_data.delete();
    model_regs  = '{default: 8'h00};
    model_carry = 1'b0;
    test_errs   = 0;
    bus_base    = bus_errs;
  endtask

  task automatic check_writes();
    assert (log_addr.size() == exp_addr.size()) else begin
      $display("ERROR at %0t: write strobe pulsed %0d times for %0d stores",
               $time, log_addr.size(), exp_addr.size());
      test_errs++;
    end
    for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
      assert (log_addr[i] == exp_addr[i]) else begin
        $display("ERROR at %0t: write %0d went to %h, expected %h",
                 $time, i, log_addr[i], exp_addr[i]);
        test_errs++;
      end
      assert (log_data[i] == exp_data[i]) else begin
        $display("ERROR at %0t: write %0d carried %h, expected %h",
                 $time, i, log_data[i], exp_data[i]);
        test_errs++;
      end
    end
  endtask

  task automatic run_and_check(input string name);
    logic [15:0] prog_end;
    int          errs;
    prog_end = PROG_BASE + 16'(prog.size());
    for (int i = 0; i < prog.size(); i++)
      mem[PROG_BASE + 16'(i)] = prog[i];
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    do begin
      @(negedge clk);
      if (mem_wr_en) begin
        mem[mem_wr_addr] = mem_wr_data;
        log_addr.push_back(mem_wr_addr);
        log_data.push_back(mem_wr_data);
      end
    end while (mem_rd_addr != prog_end);
    check_writes();
    errs = test_errs + bus_errs - bus_base;
    if (errs == 0) begin
      pass_cnt++;
      $display("test %s: ok, %0d stores checked", name, exp_addr.size());
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  task automatic imm_load_store();
    logic [7:0] p;
    begin_test();
    p = next_byte();
    set_hl({4'hC, p[3:0]});
    for (int i = 0; i < 5; i++)
      load_immediate(work_reg(i), next_byte());
    for (int r = 0; r < 8; r++)
      if (r != 6) store_to_hl(3'(r));
    run_and_check("immediate load and store");
  endtask

  task automatic reg_move_chain();
    logic [7:0] p;
    begin_test();
    p = next_byte();
    set_hl({4'hC, p[3:0]});
    for (int i = 0; i < 5; i++)
      load_immediate(work_reg(i), next_byte());
    for (int k = 0; k < 8; k++)
      copy_register(pick_reg(), pick_reg());
    for (int i = 0; i < 5; i++)
      store_to_hl(work_reg(i));
    run_and_check("register move");
  endtask

  task automatic inc_dec_wrap();
    logic [7:0] p;
    begin_test();
    p = next_byte();
    set_hl({4'hC, p[3:0]});
    load_immediate(R_B, 8'hFF);  // wraps up to 00
    load_immediate(R_C, 8'h00);  // wraps down to FF
    load_immediate(R_D, next_byte());
    load_immediate(R_E, next_byte());
    load_immediate(R_A, next_byte());
    step_register(R_B, 1'b0);
    step_register(R_C, 1'b1);
    step_register(R_D, 1'b0);
    step_register(R_E, 1'b1);
    step_register(R_A, 1'b1);
    for (int i = 0; i < 5; i++)
      store_to_hl(work_reg(i));
    run_and_check("increment and decrement");
  endtask

  task automatic carry_chain();
    logic [7:0] p;
    logic [7:0] a;
    logic [7:0] b;
    begin_test();
    p = next_byte();
    set_hl({4'hC, p[3:0]});
    for (int k = 0; k < 4; k++) begin
      a = (k == 0) ? 8'hFF : (k == 1) ? 8'h01 : next_byte();  // carry set then clear
      b = (k < 2) ? 8'h01 : next_byte();
      load_immediate(R_A, a);
      load_immediate(R_B, b);
      add_to_a(R_B, 1'b0);
      store_to_hl(R_A);
      step_register(R_C, 1'b0);
      load_immediate(R_D, next_byte());
      add_to_a(R_D, 1'b1);
      store_to_hl(R_A);
    end
    store_to_hl(R_C);
    run_and_check("carry");
  endtask

  task automatic mem_load_copy();
    logic [7:0] p;
    begin_test();
    for (int k = 0; k < 5; k++) begin
      set_hl(8'hC0 + 8'(k));  // one source page per round
      read_hl_byte(work_reg(k), next_byte());
      p = next_byte();
      set_hl({5'b11001, p[2:0]});
      store_to_hl(work_reg(k));
    end
    run_and_check("load from memory");
  endtask

  task automatic random_mix();
    logic [7:0] b;
    begin_test();
    b = next_byte();
    set_hl({4'hC, b[3:0]});
    for (int i = 0; i < 5; i++)
      load_immediate(work_reg(i), next_byte());
    for (int k = 0; k < 12; k++) begin
      b = next_byte();
      case (b[2:0])
        3'd0: copy_register(pick_reg(), pick_reg());
        3'd1: step_register(pick_reg(), 1'b0);
        3'd2: step_register(pick_reg(), 1'b1);
        3'd3: add_to_a(pick_reg(), 1'b0);
        3'd4: add_to_a(pick_reg(), 1'b1);
        3'd5: store_to_hl(pick_reg());
        default: prog.push_back(b[3] ? 8'h76 : 8'h00);  // unkept opcode runs as nop
      endcase
    end
    for (int i = 0; i < 5; i++)
      store_to_hl(work_reg(i));
    run_and_check("write strobe and mixed program");
  endtask

  initial begin
    rst       = 1'b1;
    rng_state = 32'h82ed;
    test_errs = 0;
    bus_errs  = 0;
    bus_base  = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    imm_load_store();
    reg_move_chain();
    inc_dec_wrap();
    carry_chain();
    mem_load_copy();
    random_mix();
    $display("tests run: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire cpu_isa_pkg::alu_op_t i_op,
  input  wire cpu_bus_pkg::data_t   i_a,
  input  wire cpu_bus_pkg::data_t   i_b,
  input  wire                       i_carry,
  output cpu_bus_pkg::data_t        o_result,
  output logic                      o_carry
);

  logic [8:0] sum;  // bit 8 is the carry out

  always_comb begin
    case (i_op)
      cpu_isa_pkg::ALU_ADD: sum = {1'b0, i_a} + {1'b0, i_b};
      cpu_isa_pkg::ALU_ADC: sum = {1'b0, i_a} + {1'b0, i_b} + {8'd0, i_carry};
      cpu_isa_pkg::ALU_INC: sum = {i_carry, i_b + 8'd1};  // carry untouched
      default:              sum = {i_carry, i_b - 8'd1};
    endcase
  end

  assign o_result = sum[7:0];
  assign o_carry  = sum[8];

endmodule

`default_nettype wire

//--- verilog/cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [7:0] data_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
  } wr_req_t;

endpackage

`default_nettype wire

//--- verilog/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

  // register numbers as encoded in the opcode fields
  typedef logic [2:0] reg_idx_t;

  localparam reg_idx_t REG_H   = 3'd4;
  localparam reg_idx_t REG_L   = 3'd5;
  localparam reg_idx_t REG_MEM = 3'd6;  // field value meaning (HL), no register behind it
  localparam reg_idx_t REG_A   = 3'd7;

  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_ADC,
    ALU_INC,
    ALU_DEC
  } alu_op_t;

  // 01 ddd sss
  typedef struct packed {
    logic [1:0] group;
    reg_idx_t   dst;
    reg_idx_t   src;
  } ld_fields_t;

  // 10 ooo sss
  typedef struct packed {
    logic [1:0] group;
    logic [2:0] op;
    reg_idx_t   src;
  } alu_fields_t;

  typedef union packed {
    ld_fields_t  ld;
    alu_fields_t alu;
    logic [7:0]  raw;
  } opcode_u;

  typedef enum logic [2:0] {
    UOP_NOP,
    UOP_LD_RR,
    UOP_LD_RN,
    UOP_ALU,
    UOP_LD_R_HL,
    UOP_LD_HL_R
  } uop_kind_t;

  typedef struct packed {
    uop_kind_t kind;
    reg_idx_t  dst;
    reg_idx_t  src;
    alu_op_t   alu_op;
    logic      needs_imm;  // one more byte follows the opcode
  } uop_t;

endpackage

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter int                 CLKS_PER_MCYCLE = 4,
  parameter cpu_bus_pkg::addr_t RESET_PC        = 16'h0100
) (
  input  wire                      i_clk,
  input  wire                      i_rst,
  input  wire cpu_bus_pkg::data_t  i_mem_rd_data,
  output cpu_bus_pkg::addr_t       o_mem_rd_addr,
  output logic                     o_mem_wr_en,
  output cpu_bus_pkg::addr_t       o_mem_wr_addr,
  output cpu_bus_pkg::data_t       o_mem_wr_data
);

  cpu_isa_pkg::opcode_u  opcode;
  cpu_isa_pkg::uop_t     uop;
  cpu_bus_pkg::data_t    imm;
  logic                  instr_valid;
  logic                  done;
  cpu_bus_pkg::rd_req_t  fetch_rd;
  cpu_bus_pkg::rd_req_t  exec_rd;
  cpu_bus_pkg::wr_req_t  exec_wr;
  cpu_isa_pkg::reg_idx_t rd_sel_a;
  cpu_isa_pkg::reg_idx_t rd_sel_b;
  cpu_isa_pkg::reg_idx_t wr_sel;
  logic                  wr_en;
  cpu_bus_pkg::data_t    wr_data;
  cpu_bus_pkg::data_t    rd_a;
  cpu_bus_pkg::data_t    rd_b;
  cpu_bus_pkg::addr_t    hl;
  cpu_isa_pkg::alu_op_t  alu_op;
  cpu_bus_pkg::data_t    alu_result;
  logic                  alu_carry;
  logic                  carry;

  instr_fetch #(
    .CLKS_PER_MCYCLE(CLKS_PER_MCYCLE),
    .RESET_PC       (RESET_PC)
  ) instr_fetch_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_mem_rd_data(i_mem_rd_data),
    .i_needs_imm  (uop.needs_imm),
    .i_done       (done),
    .o_rd_req     (fetch_rd),
    .o_opcode     (opcode),
    .o_imm        (imm),
    .o_instr_valid(instr_valid)
  );

  instr_decode instr_decode_i (
    .i_opcode(opcode),
    .o_uop   (uop)
  );

  exec_unit #(
    .CLKS_PER_MCYCLE(CLKS_PER_MCYCLE)
  ) exec_unit_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_instr_valid(instr_valid),
    .i_uop        (uop),
    .i_imm        (imm),
    .i_mem_rd_data(i_mem_rd_data),
    .i_rd_a       (rd_a),
    .i_rd_b       (rd_b),
    .i_hl         (hl),
    .i_alu_result (alu_result),
    .i_alu_carry  (alu_carry),
    .o_done       (done),
    .o_rd_sel_a   (rd_sel_a),
    .o_rd_sel_b   (rd_sel_b),
    .o_wr_en      (wr_en),
    .o_wr_sel     (wr_sel),
    .o_wr_data    (wr_data),
    .o_alu_op     (alu_op),
    .o_carry      (carry),
    .o_rd_req     (exec_rd),
    .o_wr_req     (exec_wr)
  );

  alu alu_i (
    .i_op    (alu_op),
    .i_a     (rd_a),
    .i_b     (rd_b),
    .i_carry (carry),
    .o_result(alu_result),
    .o_carry (alu_carry)
  );

  reg_file reg_file_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_rd_sel_a(rd_sel_a),
    .i_rd_sel_b(rd_sel_b),
    .i_wr_en   (wr_en),
    .i_wr_sel  (wr_sel),
    .i_wr_data (wr_data),
    .o_rd_a    (rd_a),
    .o_rd_b    (rd_b),
    .o_hl      (hl)
  );

  mem_port mem_port_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_fetch_rd   (fetch_rd),
    .i_exec_rd    (exec_rd),
    .i_exec_wr    (exec_wr),
    .o_mem_rd_addr(o_mem_rd_addr),
    .o_mem_wr_en  (o_mem_wr_en),
    .o_mem_wr_addr(o_mem_wr_addr),
    .o_mem_wr_data(o_mem_wr_data)
  );

endmodule

`default_nettype wire

//--- verilog/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
  parameter int CLKS_PER_MCYCLE = 4
) (
  input  wire                          i_clk,
  input  wire                          i_rst,
  input  wire                          i_instr_valid,
  input  wire cpu_isa_pkg::uop_t       i_uop,
  input  wire cpu_bus_pkg::data_t      i_imm,
  input  wire cpu_bus_pkg::data_t      i_mem_rd_data,
  input  wire cpu_bus_pkg::data_t      i_rd_a,
  input  wire cpu_bus_pkg::data_t      i_rd_b,
  input  wire cpu_bus_pkg::addr_t      i_hl,
  input  wire cpu_bus_pkg::data_t      i_alu_result,
  input  wire                          i_alu_carry,
  output logic                         o_done,
  output cpu_isa_pkg::reg_idx_t        o_rd_sel_a,
  output cpu_isa_pkg::reg_idx_t        o_rd_sel_b,
  output logic                         o_wr_en,
  output cpu_isa_pkg::reg_idx_t        o_wr_sel,
  output cpu_bus_pkg::data_t           o_wr_data,
  output cpu_isa_pkg::alu_op_t         o_alu_op,
  output logic                         o_carry,
  output cpu_bus_pkg::rd_req_t         o_rd_req,
  output cpu_bus_pkg::wr_req_t         o_wr_req
);

  localparam int               CNT_W    = $clog2(CLKS_PER_MCYCLE);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_MCYCLE - 1);

  logic [CNT_W-1:0]   cnt;
  logic               mcyc;      // second machine cycle of a memory op
  logic               two_cyc;
  logic               last_clk;
  logic               bus_clk;
  cpu_bus_pkg::data_t rd_hold;

  assign two_cyc  = (i_uop.kind == cpu_isa_pkg::UOP_LD_R_HL) ||
                    (i_uop.kind == cpu_isa_pkg::UOP_LD_HL_R);
  assign last_clk = i_instr_valid && (cnt == CNT_LAST);
  assign bus_clk  = i_instr_valid && !mcyc && (cnt == '0);
  assign o_done   = last_clk && (mcyc == two_cyc);

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      cnt     <= '0;
      mcyc    <= 1'b0;
      o_carry <= 1'b0;
    end else if (i_instr_valid) begin
      cnt <= last_clk ? '0 : cnt + 1'b1;
      if (o_done)
        mcyc <= 1'b0;
      else if (last_clk)
        mcyc <= 1'b1;
      // inc/dec hand the old carry back unchanged
      if (o_done && i_uop.kind == cpu_isa_pkg::UOP_ALU)
        o_carry <= i_alu_carry;
    end
  end

  // memory byte sampled at the end of the bus cycle
  always_ff @(posedge i_clk) begin
    if (last_clk && !mcyc && i_uop.kind == cpu_isa_pkg::UOP_LD_R_HL)
      rd_hold <= i_mem_rd_data;
  end

  assign o_rd_sel_a = (i_uop.kind == cpu_isa_pkg::UOP_LD_HL_R) ? i_uop.src : cpu_isa_pkg::REG_A;
  assign o_rd_sel_b = i_uop.src;
  assign o_wr_sel   = i_uop.dst;
  assign o_alu_op   = i_uop.alu_op;

  always_comb begin
    o_wr_en   = 1'b0;
    o_wr_data = i_rd_b;
    case (i_uop.kind)
      cpu_isa_pkg::UOP_LD_RR: o_wr_en = o_done;
      cpu_isa_pkg::UOP_LD_RN: begin
        o_wr_en   = o_done;
        o_wr_data = i_imm;
      end
      cpu_isa_pkg::UOP_ALU: begin
        o_wr_en   = o_done;
        o_wr_data = i_alu_result;
      end
      cpu_isa_pkg::UOP_LD_R_HL: begin
        o_wr_en   = o_done;
        o_wr_data = rd_hold;
      end
      default: ;
    endcase
  end

  always_comb begin
    o_rd_req.valid = bus_clk && (i_uop.kind == cpu_isa_pkg::UOP_LD_R_HL);
    o_rd_req.addr  = i_hl;
    o_wr_req.valid = bus_clk && (i_uop.kind == cpu_isa_pkg::UOP_LD_HL_R);
    o_wr_req.addr  = i_hl;
    o_wr_req.data  = i_rd_a;
  end

endmodule

`default_nettype wire

//--- verilog/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input  wire cpu_isa_pkg::opcode_u i_opcode,
  output cpu_isa_pkg::uop_t         o_uop
);

  always_comb begin
    o_uop = '0;  // nop
    case (i_opcode.ld.group)
      2'd0: begin
        // ld r,n / inc r / dec r, picked by the low field
        o_uop.dst = i_opcode.ld.dst;
        o_uop.src = i_opcode.ld.dst;
        if (i_opcode.ld.dst != cpu_isa_pkg::REG_MEM) begin
          case (i_opcode.ld.src)
            3'd4: begin
              o_uop.kind   = cpu_isa_pkg::UOP_ALU;
              o_uop.alu_op = cpu_isa_pkg::ALU_INC;
            end
            3'd5: begin
              o_uop.kind   = cpu_isa_pkg::UOP_ALU;
              o_uop.alu_op = cpu_isa_pkg::ALU_DEC;
            end
            3'd6: begin
              o_uop.kind      = cpu_isa_pkg::UOP_LD_RN;
              o_uop.needs_imm = 1'b1;
            end
            default: ;
          endcase
        end
      end
      2'd1: begin
        o_uop.dst = i_opcode.ld.dst;
        o_uop.src = i_opcode.ld.src;
        if (i_opcode.ld.src == cpu_isa_pkg::REG_MEM) begin
          if (i_opcode.ld.dst != cpu_isa_pkg::REG_MEM)  // 0x76 stays nop
            o_uop.kind = cpu_isa_pkg::UOP_LD_R_HL;
        end else if (i_opcode.ld.dst == cpu_isa_pkg::REG_MEM) begin
          o_uop.kind = cpu_isa_pkg::UOP_LD_HL_R;
        end else begin
          o_uop.kind = cpu_isa_pkg::UOP_LD_RR;
        end
      end
      2'd2: begin
        o_uop.dst    = cpu_isa_pkg::REG_A;
        o_uop.src    = i_opcode.alu.src;
        o_uop.alu_op = i_opcode.alu.op[0] ? cpu_isa_pkg::ALU_ADC : cpu_isa_pkg::ALU_ADD;
        if (i_opcode.alu.op[2:1] == 2'b00 && i_opcode.alu.src != cpu_isa_pkg::REG_MEM)
          o_uop.kind = cpu_isa_pkg::UOP_ALU;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch #(
  parameter int                 CLKS_PER_MCYCLE = 4,
  parameter cpu_bus_pkg::addr_t RESET_PC        = 16'h0100
) (
  input  wire                        i_clk,
  input  wire                        i_rst,
  input  wire cpu_bus_pkg::data_t    i_mem_rd_data,
  input  wire                        i_needs_imm,
  input  wire                        i_done,
  output cpu_bus_pkg::rd_req_t       o_rd_req,
  output cpu_isa_pkg::opcode_u       o_opcode,
  output cpu_bus_pkg::data_t         o_imm,
  output logic                       o_instr_valid
);

  localparam int               CNT_W    = $clog2(CLKS_PER_MCYCLE);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_MCYCLE - 1);

  typedef enum logic [1:0] {
    S_OP,
    S_IMM,
    S_WAIT
  } state_t;

  state_t             state;
  logic [CNT_W-1:0]   cnt;
  cpu_bus_pkg::addr_t pc;
  logic               imm_cyc;
  logic               last_clk;

  // S_IMM doubles as the wait state when the opcode has no immediate
  assign imm_cyc       = (state == S_IMM) && i_needs_imm;
  assign last_clk      = (cnt == CNT_LAST);
  assign o_instr_valid = (state == S_WAIT) || ((state == S_IMM) && !i_needs_imm);

  always_comb begin
    o_rd_req.valid = ((state == S_OP) || imm_cyc) && (cnt == '0);
    o_rd_req.addr  = pc;
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state    <= S_OP;
      cnt      <= '0;
      pc       <= RESET_PC;
      o_opcode <= '0;  // decodes as nop
    end else begin
      if ((state == S_OP) || imm_cyc)
        cnt <= last_clk ? '0 : cnt + 1'b1;
      case (state)
        S_OP: begin
          if (last_clk) begin
            o_opcode.raw <= i_mem_rd_data;
            pc           <= pc + 16'd1;
            state        <= S_IMM;
          end
        end
        S_IMM: begin
          if (i_needs_imm) begin
            if (last_clk) begin
              pc    <= pc + 16'd1;
              state <= S_WAIT;
            end
          end else if (i_done) begin
            state <= S_OP;
          end
        end
        S_WAIT: if (i_done) state <= S_OP;
        default: state <= S_OP;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (imm_cyc && last_clk)
      o_imm <= i_mem_rd_data;
  end

endmodule

`default_nettype wire

//--- verilog/mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port (
  input  wire                        i_clk,
  input  wire                        i_rst,
  input  wire cpu_bus_pkg::rd_req_t  i_fetch_rd,
  input  wire cpu_bus_pkg::rd_req_t  i_exec_rd,
  input  wire cpu_bus_pkg::wr_req_t  i_exec_wr,
  output cpu_bus_pkg::addr_t         o_mem_rd_addr,
  output logic                       o_mem_wr_en,
  output cpu_bus_pkg::addr_t         o_mem_wr_addr,
  output cpu_bus_pkg::data_t         o_mem_wr_data
);

  cpu_bus_pkg::rd_req_t rd_pick;

  // fetch and exec never request in the same clock
  assign rd_pick = i_fetch_rd.valid ? i_fetch_rd : i_exec_rd;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_mem_rd_addr <= '0;
      o_mem_wr_en   <= 1'b0;
      o_mem_wr_addr <= '0;
      o_mem_wr_data <= '0;
    end else begin
      if (rd_pick.valid)
        o_mem_rd_addr <= rd_pick.addr;  // held until the next request
      o_mem_wr_en <= i_exec_wr.valid;   // request lasts one clock, so does the strobe
      if (i_exec_wr.valid) begin
        o_mem_wr_addr <= i_exec_wr.addr;
        o_mem_wr_data <= i_exec_wr.data;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire                          i_clk,
  input  wire                          i_rst,
  input  wire cpu_isa_pkg::reg_idx_t   i_rd_sel_a,
  input  wire cpu_isa_pkg::reg_idx_t   i_rd_sel_b,
  input  wire                          i_wr_en,
  input  wire cpu_isa_pkg::reg_idx_t   i_wr_sel,
  input  wire cpu_bus_pkg::data_t      i_wr_data,
  output cpu_bus_pkg::data_t           o_rd_a,
  output cpu_bus_pkg::data_t           o_rd_b,
  output cpu_bus_pkg::addr_t           o_hl
);

  cpu_bus_pkg::data_t regs [8];  // B C D E H L - A

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      for (int i = 0; i < 8; i++)
        regs[i] <= '0;
    end else if (i_wr_en && i_wr_sel != cpu_isa_pkg::REG_MEM) begin
      regs[i_wr_sel] <= i_wr_data;
    end
  end

  assign o_rd_a = regs[i_rd_sel_a];
  assign o_rd_b = regs[i_rd_sel_b];
  assign o_hl   = {regs[cpu_isa_pkg::REG_H], regs[cpu_isa_pkg::REG_L]};

endmodule

`default_nettype wire
